// ==== Makefile ====
# Verilator build and run of the cache testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cacheTb
FILELIST  = compile.f
BUILD_DIR = obj_dir
PASS_MSG  = All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# Pass or fail comes from the pass message in the simulation output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
rtl/cachePkg.sv
rtl/requestQueue.sv
rtl/cacheArray.sv
rtl/cacheController.sv
rtl/mainMemory.sv
rtl/cacheTop.sv
tb/cacheTb.sv

// ==== rtl/cacheArray.sv ====
`timescale 1ns/10ps

module cacheArray (
    input  logic                         CLK,
    input  logic                         Reset,
    input  cachePkg::CacheAddr           LookupAddr,
    input  logic                         ArrayWrite,
    input  logic [31:0]                  ArrayWData,
    input  logic                         ArrayDirty,
    output logic                         Hit,
    output logic                         LineValid,
    output logic                         LineDirty,
    output logic [31:0]                  LineData,
    output logic [cachePkg::TagBits-1:0] VictimTag
);

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    // Data and tag memories hold meaning only where valid
    logic [31:0]                  DataMem [cachePkg::Lines];
    logic [cachePkg::TagBits-1:0] TagMem  [cachePkg::Lines];

    // Per line status bits
    logic [cachePkg::Lines-1:0] ValidBits;
    logic [cachePkg::Lines-1:0] DirtyBits;

    logic [cachePkg::IndexBits-1:0] Index;
    logic [cachePkg::TagBits-1:0]   StoredTag;

    assign Index = LookupAddr.fields.index;

    // Line write takes the tag of the lookup address
    always_ff @(posedge CLK) begin
        if (ArrayWrite) begin
            DataMem[Index] <= ArrayWData;
            TagMem[Index]  <= LookupAddr.fields.tag;
        end
    end

    // Every line invalid and clean after reset
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            ValidBits <= '0;
            DirtyBits <= '0;
        end else if (ArrayWrite) begin
            ValidBits[Index] <= 1'b1;
            DirtyBits[Index] <= ArrayDirty;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////////////////////////

    assign StoredTag = TagMem[Index];

    // Full 22-bit tag compare gated by valid
    assign Hit       = ValidBits[Index] & (StoredTag == LookupAddr.fields.tag);
    assign LineValid = ValidBits[Index];
    assign LineDirty = DirtyBits[Index];
    assign LineData  = DataMem[Index];

    // Old tag of the line rebuilds the writeback address
    assign VictimTag = StoredTag;

endmodule

// ==== rtl/cacheController.sv ====
`timescale 1ns/10ps

module cacheController (
    input  logic                         CLK,
    input  logic                         Reset,
    input  logic                         HeadValid,
    input  logic                         HeadWrite,
    input  logic [31:0]                  HeadAddr,
    input  logic [31:0]                  HeadWData,
    input  logic                         Hit,
    input  logic                         LineValid,
    input  logic                         LineDirty,
    input  logic [31:0]                  LineData,
    input  logic [cachePkg::TagBits-1:0] VictimTag,
    input  logic                         MemDone,
    input  logic [31:0]                  MemRData,
    output logic                         Pop,
    output cachePkg::CacheAddr           LookupAddr,
    output logic                         ArrayWrite,
    output logic [31:0]                  ArrayWData,
    output logic                         ArrayDirty,
    output logic                         MemReq,
    output logic                         MemWrite,
    output logic [31:0]                  MemAddr,
    output logic [31:0]                  MemWData,
    output logic                         RespValid,
    output logic [31:0]                  RespData,
    output logic                         RespHit
);

    cachePkg::CtrlState State;

    // Request held from Pop until Respond
    logic               ReqIsWrite;
    cachePkg::CacheAddr ReqAddr;
    logic [31:0]        ReqWData;

    // Hit result from Lookup since the line may change before Respond
    logic HitReg;

    // Memory transaction issued and not yet done
    logic Pending;

    // Word returned by the fill read
    logic [31:0] FillData;

    // Writeback address rebuilt from the victim tag
    cachePkg::CacheAddr WbAddr;

    //////////////////////////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            State   <= cachePkg::Idle;
            HitReg  <= 1'b0;
            Pending <= 1'b0;
        end else begin
            // Issue marks pending and done clears it
            if (MemReq) begin
                Pending <= 1'b1;
            end else if (MemDone) begin
                Pending <= 1'b0;
            end
            case (State)
                cachePkg::Idle: begin
                    if (HeadValid) begin
                        State <= cachePkg::Lookup;
                    end
                end
                cachePkg::Lookup: begin
                    HitReg <= Hit;
                    if (Hit) begin
                        State <= cachePkg::Respond;
                    end else if (LineValid && LineDirty) begin
                        State <= cachePkg::WriteBack;
                    end else begin
                        State <= cachePkg::Fill;
                    end
                end
                cachePkg::WriteBack: begin
                    if (MemDone) begin
                        State <= cachePkg::Fill;
                    end
                end
                cachePkg::Fill: begin
                    if (MemDone) begin
                        State <= cachePkg::Update;
                    end
                end
                cachePkg::Update: State <= cachePkg::Respond;
                default:          State <= cachePkg::Idle;
            endcase
        end
    end

    // Request capture on Pop and fill word capture on read completion
    always_ff @(posedge CLK) begin
        if (Pop) begin
            ReqIsWrite  <= HeadWrite;
            ReqAddr.raw <= HeadAddr;
            ReqWData    <= HeadWData;
        end
        if ((State == cachePkg::Fill) && MemDone) begin
            FillData <= MemRData;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////////////////////////

    // Take the head in the same cycle it is seen
    assign Pop = (State == cachePkg::Idle) && HeadValid;

    assign LookupAddr = ReqAddr;

    always_comb begin
        WbAddr              = ReqAddr;
        WbAddr.fields.tag   = VictimTag;
        WbAddr.fields.offset = '0;
    end

    // One request per memory phase
    assign MemReq   = ((State == cachePkg::WriteBack) || (State == cachePkg::Fill)) && !Pending;
    assign MemWrite = (State == cachePkg::WriteBack);
    assign MemAddr  = MemWrite ? WbAddr.raw : ReqAddr.raw;
    // Victim line still in the array during writeback
    assign MemWData = LineData;

    // Miss update or write hit at Respond
    assign ArrayWrite = (State == cachePkg::Update) ||
                        ((State == cachePkg::Respond) && HitReg && ReqIsWrite);
    // Read miss stores clean fill data and writes store dirty
    assign ArrayWData = ReqIsWrite ? ReqWData : FillData;
    assign ArrayDirty = ReqIsWrite;

    assign RespValid = (State == cachePkg::Respond);
    // Reads see the line as it stands after any update
    assign RespData  = ReqIsWrite ? ReqWData : LineData;
    assign RespHit   = HitReg;

    // Memory request only on the first cycle of a miss phase
    assert property (@(posedge CLK) disable iff (Reset)
        MemReq |-> (State inside {cachePkg::WriteBack, cachePkg::Fill}) &&
        (State != $past(State)));

    // Response follows a hit Lookup or an Update
    assert property (@(posedge CLK) disable iff (Reset)
        RespValid |-> (($past(State) == cachePkg::Lookup) && RespHit) ||
        ($past(State) == cachePkg::Update));

endmodule

// ==== rtl/cachePkg.sv ====
package cachePkg;

    //////////////////////////////////////////////////////////////////////
    // Cache geometry
    //////////////////////////////////////////////////////////////////////

    // Direct mapped, one 32-bit word per line
    localparam int TagBits    = 22;
    localparam int IndexBits  = 8;
    localparam int OffsetBits = 2;
    localparam int Lines      = 1 << IndexBits;

    //////////////////////////////////////////////////////////////////////
    // Address word
    //////////////////////////////////////////////////////////////////////

    // Raw view for ports and memory
    // Fields view for array indexing and tag compare
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            // Bits 31 to 10
            logic [TagBits-1:0]    tag;
            // Bits 9 to 2, selects the line
            logic [IndexBits-1:0]  index;
            // Byte inside the word, ignored by the cache
            logic [OffsetBits-1:0] offset;
        } fields;
    } CacheAddr;

    //////////////////////////////////////////////////////////////////////
    // Controller states
    //////////////////////////////////////////////////////////////////////

    // Idle       wait for a queued request and pop it
    // Lookup     array compare on the held address
    // WriteBack  dirty victim goes out to memory
    // Fill       line is read from memory
    // Update     array takes the fill or the write word
    // Respond    one response pulse to the processor
    typedef enum logic [2:0] {
        Idle,
        Lookup,
        WriteBack,
        Fill,
        Update,
        Respond
    } CtrlState;

endpackage

// ==== rtl/cacheTop.sv ====
`timescale 1ns/10ps

module cacheTop #(
    parameter int QueueDepth = 4,
    parameter int MemLatency = 5,
    parameter int MemWords   = 4096
) (
    input  logic        CLK,
    input  logic        Reset,
    input  logic        ReqValid,
    input  logic        ReqWrite,
    input  logic [31:0] ReqAddr,
    input  logic [31:0] ReqWData,
    output logic        CreditReturn,
    output logic        RespValid,
    output logic [31:0] RespData,
    output logic        RespHit
);

    //////////////////////////////////////////////////////////////////////
    // Interconnect
    //////////////////////////////////////////////////////////////////////

    // Queue head
    logic        HeadValid;
    logic        HeadWrite;
    logic [31:0] HeadAddr;
    logic [31:0] HeadWData;
    logic        Pop;

    // Array port
    cachePkg::CacheAddr           LookupAddr;
    logic                         Hit;
    logic                         LineValid;
    logic                         LineDirty;
    logic [31:0]                  LineData;
    logic [cachePkg::TagBits-1:0] VictimTag;
    logic                         ArrayWrite;
    logic [31:0]                  ArrayWData;
    logic                         ArrayDirty;

    // Memory port
    logic        MemReq;
    logic        MemWrite;
    logic [31:0] MemAddr;
    logic [31:0] MemWData;
    logic        MemDone;
    logic [31:0] MemRData;

    requestQueue #(.QueueDepth(QueueDepth)) i_requestQueue (
        .CLK(CLK), .Reset(Reset),
        .ReqValid(ReqValid), .ReqWrite(ReqWrite), .ReqAddr(ReqAddr), .ReqWData(ReqWData),
        .Pop(Pop), .HeadValid(HeadValid), .HeadWrite(HeadWrite),
        .HeadAddr(HeadAddr), .HeadWData(HeadWData), .CreditReturn(CreditReturn)
    );

    cacheController i_cacheController (
        .CLK(CLK), .Reset(Reset),
        .HeadValid(HeadValid), .HeadWrite(HeadWrite), .HeadAddr(HeadAddr),
        .HeadWData(HeadWData), .Hit(Hit), .LineValid(LineValid), .LineDirty(LineDirty),
        .LineData(LineData), .VictimTag(VictimTag), .MemDone(MemDone), .MemRData(MemRData),
        .Pop(Pop), .LookupAddr(LookupAddr), .ArrayWrite(ArrayWrite),
        .ArrayWData(ArrayWData), .ArrayDirty(ArrayDirty), .MemReq(MemReq),
        .MemWrite(MemWrite), .MemAddr(MemAddr), .MemWData(MemWData),
        .RespValid(RespValid), .RespData(RespData), .RespHit(RespHit)
    );

    cacheArray i_cacheArray (
        .CLK(CLK), .Reset(Reset),
        .LookupAddr(LookupAddr), .ArrayWrite(ArrayWrite), .ArrayWData(ArrayWData),
        .ArrayDirty(ArrayDirty), .Hit(Hit), .LineValid(LineValid), .LineDirty(LineDirty),
        .LineData(LineData), .VictimTag(VictimTag)
    );

    mainMemory #(.MemLatency(MemLatency), .MemWords(MemWords)) i_mainMemory (
        .CLK(CLK), .Reset(Reset),
        .MemReq(MemReq), .MemWrite(MemWrite), .MemAddr(MemAddr), .MemWData(MemWData),
        .MemDone(MemDone), .MemRData(MemRData)
    );

endmodule

// ==== rtl/mainMemory.sv ====
`timescale 1ns/10ps

module mainMemory #(
    parameter int MemLatency = 5,
    parameter int MemWords   = 4096
) (
    input  logic        CLK,
    input  logic        Reset,
    input  logic        MemReq,
    input  logic        MemWrite,
    input  logic [31:0] MemAddr,
    input  logic [31:0] MemWData,
    output logic        MemDone,
    output logic [31:0] MemRData
);

    // Word index from the byte address, higher bits alias
    localparam int WordBits  = $clog2(MemWords);
    localparam int CountBits = $clog2(MemLatency + 1);

    logic [31:0] MemArray [MemWords];

    // Captured request
    logic                WriteReg;
    logic [WordBits-1:0] WordIdx;
    logic [31:0]         WDataReg;

    // Access in flight and cycles left
    logic                 Busy;
    logic [CountBits-1:0] Count;

    // Backing store starts at zero
    initial begin
        for (int i = 0; i < MemWords; i++) begin
            MemArray[i] = '0;
        end
    end

    // Latency counter, down to zero in the done cycle
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            Busy  <= 1'b0;
            Count <= '0;
        end else if (MemReq) begin
            Busy  <= 1'b1;
            Count <= CountBits'(MemLatency - 1);
        end else if (MemDone) begin
            Busy <= 1'b0;
        end else if (Busy) begin
            Count <= Count - 1'b1;
        end
    end

    // Request capture, write commits at completion
    always_ff @(posedge CLK) begin
        if (MemReq) begin
            WriteReg <= MemWrite;
            WordIdx  <= MemAddr[WordBits+1:2];
            WDataReg <= MemWData;
        end
        if (MemDone && WriteReg) begin
            MemArray[WordIdx] <= WDataReg;
        end
    end

    assign MemDone  = Busy && (Count == '0);
    // Read word valid in the done cycle
    assign MemRData = MemArray[WordIdx];

    // Completion exactly MemLatency cycles after the request
    assert property (@(posedge CLK) disable iff (Reset)
        MemReq |-> ##MemLatency MemDone);

endmodule

// ==== rtl/requestQueue.sv ====
`timescale 1ns/10ps

module requestQueue #(
    parameter int QueueDepth = 4
) (
    input  logic        CLK,
    input  logic        Reset,
    input  logic        ReqValid,
    input  logic        ReqWrite,
    input  logic [31:0] ReqAddr,
    input  logic [31:0] ReqWData,
    input  logic        Pop,
    output logic        HeadValid,
    output logic        HeadWrite,
    output logic [31:0] HeadAddr,
    output logic [31:0] HeadWData,
    output logic        CreditReturn
);

    // Pointer width stays one bit for a single entry queue
    localparam int PtrBits   = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CountBits = $clog2(QueueDepth + 1);

    // Entry storage
    logic        WriteMem [QueueDepth];
    logic [31:0] AddrMem  [QueueDepth];
    logic [31:0] WDataMem [QueueDepth];

    logic [PtrBits-1:0]   WrPtr;
    logic [PtrBits-1:0]   RdPtr;
    logic [CountBits-1:0] Count;

    // Entry payload
    always_ff @(posedge CLK) begin
        if (ReqValid) begin
            WriteMem[WrPtr] <= ReqWrite;
            AddrMem[WrPtr]  <= ReqAddr;
            WDataMem[WrPtr] <= ReqWData;
        end
    end

    // Pointers wrap at QueueDepth, which need not be a power of two
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            WrPtr <= '0;
            RdPtr <= '0;
            Count <= '0;
        end else begin
            if (ReqValid) begin
                WrPtr <= (WrPtr == PtrBits'(QueueDepth - 1)) ? '0 : WrPtr + 1'b1;
            end
            if (Pop) begin
                RdPtr <= (RdPtr == PtrBits'(QueueDepth - 1)) ? '0 : RdPtr + 1'b1;
            end
            // Simultaneous push and pop keeps the count
            case ({ReqValid, Pop})
                2'b10:   Count <= Count + 1'b1;
                2'b01:   Count <= Count - 1'b1;
                default: Count <= Count;
            endcase
        end
    end

    // Head entry straight from storage
    assign HeadValid = (Count != '0);
    assign HeadWrite = WriteMem[RdPtr];
    assign HeadAddr  = AddrMem[RdPtr];
    assign HeadWData = WDataMem[RdPtr];

    // One credit back per entry taken by the controller
    assign CreditReturn = Pop;

    // Sender credit accounting must keep a full queue from taking a push
    assert property (@(posedge CLK) disable iff (Reset)
        ReqValid |-> (Count < CountBits'(QueueDepth)));

    // Controller only pops what it was shown
    assert property (@(posedge CLK) disable iff (Reset)
        Pop |-> (Count != '0));

endmodule

// ==== tb/cacheTb.sv ====
`timescale 1ns/10ps

module cacheTb;

    //////////////////////////////////////////////////////////////////////
    // Test setup
    //////////////////////////////////////////////////////////////////////

    localparam int QueueDepth  = 4;
    localparam int MemLatency  = 5;
    localparam int MemWords    = 4096;
    localparam int ClkPeriod   = 20;
    localparam int ResetCycles = 16;
    localparam int NumReqs     = 400;
    // Worst case per request: lookup, writeback, fill, update, respond, idle
    localparam int WorstCycles = 2 * MemLatency + 10;
    localparam int TimeoutNs   = (ResetCycles + NumReqs * WorstCycles + 200) * ClkPeriod;

    logic        CLK;
    logic        Reset;
    logic        ReqValid;
    logic        ReqWrite;
    logic [31:0] ReqAddr;
    logic [31:0] ReqWData;
    logic        CreditReturn;
    logic        RespValid;
    logic [31:0] RespData;
    logic        RespHit;

    // Sender side bookkeeping
    int credits;
    int sentCount;
    int returnCount;
    int respCount;
    int errorCount;
    int protocolErrors;
    int dirtyEvictions;

    // Expected responses in request order
    logic [31:0] expData[$];
    logic        expHit[$];

    // Reference model, flat word memory plus per line state
    logic [31:0] modelMem   [MemWords];
    logic [21:0] modelTag   [256];
    logic        modelValid [256];
    logic        modelDirty [256];

    cacheTop #(
        .QueueDepth(QueueDepth),
        .MemLatency(MemLatency),
        .MemWords(MemWords)
    ) i_dut (
        .CLK(CLK), .Reset(Reset),
        .ReqValid(ReqValid), .ReqWrite(ReqWrite), .ReqAddr(ReqAddr), .ReqWData(ReqWData),
        .CreditReturn(CreditReturn), .RespValid(RespValid), .RespData(RespData),
        .RespHit(RespHit)
    );

    initial begin
        CLK = 1'b0;
        forever #(ClkPeriod / 2) CLK = ~CLK;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Value compare with a report on mismatch
    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED time=%0t signal=%s actual=%h expected=%h",
                     $time, name, actual, expected);
        end
    endtask

    // 4 tags and 8 spread indexes, all below 16 KB
    function automatic logic [31:0] makeAddr(input int tagSel, input int idxSel);
        logic [21:0] tag;
        logic [7:0]  index;
        tag   = 22'(tagSel * 5);
        index = 8'(idxSel * 33);
        return {tag, index, 2'b00};
    endfunction

    // Model update in request order, then drive the request
    task automatic issueRequest(input logic isWrite, input logic [31:0] addr,
                                input logic [31:0] wdata);
        logic [21:0] tag;
        logic [7:0]  index;
        logic [11:0] word;
        logic        hit;
        tag   = addr[31:10];
        index = addr[9:2];
        word  = addr[13:2];
        hit   = modelValid[index] && (modelTag[index] == tag);
        if (!hit && modelValid[index] && modelDirty[index]) begin
            dirtyEvictions++;
        end
        if (isWrite) begin
            modelMem[word] = wdata;
        end
        expData.push_back(modelMem[word]);
        expHit.push_back(hit);
        // Read hit keeps dirty, read miss fills clean, any write leaves it dirty
        if (isWrite) begin
            modelDirty[index] = 1'b1;
        end else if (!hit) begin
            modelDirty[index] = 1'b0;
        end
        modelValid[index] = 1'b1;
        modelTag[index]   = tag;
        ReqValid <= 1'b1;
        ReqWrite <= isWrite;
        ReqAddr  <= addr;
        ReqWData <= wdata;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Monitors on the falling edge, outputs are settled there
    //////////////////////////////////////////////////////////////////////

    always @(negedge CLK) begin
        if (CreditReturn) begin
            credits++;
            returnCount++;
            if (credits > QueueDepth) begin
                protocolErrors++;
                $display("Credit returned beyond the queue depth at %0t", $time);
            end
        end
        if (RespValid) begin
            if (expData.size() == 0) begin
                protocolErrors++;
                $display("Response without a pending request at %0t", $time);
            end else begin
                checkValue("RespData", RespData, expData.pop_front());
                checkValue("RespHit", {31'b0, RespHit}, {31'b0, expHit.pop_front()});
                respCount++;
            end
        end
    end

    // Watchdog sized from the request count and the worst miss time
    initial begin
        #(TimeoutNs);
        $display("Timeout: only %0d of %0d responses arrived", respCount, NumReqs);
        $display("Some tests failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] addr;
        logic [31:0] lastAddr;
        logic        lastWrite;
        void'($urandom(32'h39f78a78));
        Reset    = 1'b1;
        ReqValid = 1'b0;
        ReqWrite = 1'b0;
        ReqAddr  = '0;
        ReqWData = '0;
        credits        = QueueDepth;
        sentCount      = 0;
        returnCount    = 0;
        respCount      = 0;
        errorCount     = 0;
        protocolErrors = 0;
        dirtyEvictions = 0;
        lastAddr       = '0;
        lastWrite      = 1'b0;
        for (int i = 0; i < MemWords; i++) begin
            modelMem[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            modelTag[i]   = '0;
            modelValid[i] = 1'b0;
            modelDirty[i] = 1'b0;
        end
        repeat (ResetCycles) @(posedge CLK);
        Reset <= 1'b0;
        @(posedge CLK);
        while (sentCount < NumReqs) begin
            @(posedge CLK);
            // Send only with a credit in hand, idle now and then
            if (credits > 0 && $urandom_range(0, 3) != 0) begin
                credits--;
                sentCount++;
                if (lastWrite && $urandom_range(0, 3) == 0) begin
                    // Read back the word just written
                    issueRequest(1'b0, lastAddr, '0);
                    lastWrite = 1'b0;
                end else begin
                    addr      = makeAddr($urandom_range(0, 3), $urandom_range(0, 7));
                    lastWrite = $urandom_range(0, 1) == 1;
                    lastAddr  = addr;
                    issueRequest(lastWrite, addr, $urandom);
                end
            end else begin
                ReqValid <= 1'b0;
            end
        end
        @(posedge CLK);
        ReqValid <= 1'b0;
        while (respCount < NumReqs) begin
            @(posedge CLK);
        end
        // Quiet cycles to catch a stray response
        repeat (20) @(posedge CLK);
        if (returnCount != sentCount) begin
            protocolErrors++;
            $display("Credit returns %0d do not match requests sent %0d", returnCount, sentCount);
        end
        if (expData.size() != 0) begin
            protocolErrors++;
            $display("%0d requests never got a response", expData.size());
        end
        $display("Requests %0d, responses %0d, dirty evictions %0d, value errors %0d, protocol errors %0d",
                 sentCount, respCount, dirtyEvictions, errorCount, protocolErrors);
        if (errorCount == 0 && protocolErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
